// File: hw/csr_pkg.sv
/*
 * Machine and debug CSR definitions shared by the trap unit.
 * Holds the standard addresses, the bit positions the trap logic touches,
 * reset values and the write bundle used by the core and the trap FSM.
 */
package csr_pkg;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_DCSR    = 12'h7b0;
    localparam logic [11:0] CSR_DPC     = 12'h7b1;

    localparam int MSTATUS_MIE_BIT = 3;  // global interrupt enable
    localparam int MIE_MSIE_BIT    = 3;
    localparam int MIE_MTIE_BIT    = 7;
    localparam int MIE_MEIE_BIT    = 11;

    localparam int DCSR_STEP_BIT  = 2;  // single step enable
    localparam int DCSR_CAUSE_LSB = 6;  // 3-bit cause field starts here

    localparam logic [31:0] CPU_RESET_ADDR = 32'h0000_0000;
    localparam logic [31:0] MTVEC_RESET    = 32'h0000_0100;

    typedef struct packed {
        logic        we;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wr_t;

endpackage

// File: hw/trap_pkg.sv
/*
 * Trap and debug-entry definitions.
 * Cause codes, the mtvec offset table, FSM states, debug causes and the
 * request and redirect bundles passed between the trap unit blocks.
 */
package trap_pkg;

    // offset table added to the mtvec base, exceptions first
    localparam logic [31:0] OFS_ILLEGAL        = 32'd0;  // reserved
    localparam logic [31:0] OFS_INSTR_MISALIGN = 32'd4;  // reserved
    localparam logic [31:0] OFS_ECALL          = 32'd8;
    localparam logic [31:0] OFS_EBREAK         = 32'd12; // reserved
    localparam logic [31:0] OFS_LOAD_MISALIGN  = 32'd16; // reserved
    localparam logic [31:0] OFS_STORE_MISALIGN = 32'd20; // reserved
    localparam logic [31:0] OFS_RSVD0          = 32'd24;
    localparam logic [31:0] OFS_RSVD1          = 32'd28;
    localparam logic [31:0] OFS_EXTERNAL       = 32'd32;
    localparam logic [31:0] OFS_SOFTWARE       = 32'd36;
    localparam logic [31:0] OFS_TIMER          = 32'd40;
    localparam logic [31:0] OFS_FAST           = 32'd44; // fast line n at 44 + 4n

    localparam logic [31:0] CAUSE_IRQ_EXTERNAL = 32'h8000_000b;
    localparam logic [31:0] CAUSE_IRQ_SOFTWARE = 32'h8000_0003;
    localparam logic [31:0] CAUSE_IRQ_TIMER    = 32'h8000_0007;
    localparam logic [31:0] CAUSE_IRQ_FAST0    = 32'h8000_0010; // plus line index
    localparam logic [31:0] CAUSE_ECALL        = 32'h0000_000b;

    localparam int TRIG_HOLDOFF = 5;  // cycles a trigger stays disarmed after dret

    typedef enum logic [4:0] {
        IDLE      = 5'b00001,
        W_MSTATUS = 5'b00010,
        W_MEPC    = 5'b00100,
        W_DCSR    = 5'b01000,
        ASSERT    = 5'b10000
    } trap_state_e;

    typedef enum logic [2:0] {
        NONE    = 3'd0,
        EBREAK  = 3'd1,
        TRIGGER = 3'd2,
        DBGREQ  = 3'd3,
        STEP    = 3'd4,
        HALT    = 3'd5
    } dcsr_cause_e;

    typedef struct packed {
        logic        valid;
        logic        executed;
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic        dret;
        logic [31:0] addr;
    } inst_info_t;

    typedef struct packed {
        logic        software;
        logic        timer;
        logic        external;
        logic [14:0] fast;
    } irq_lines_t;

    typedef struct packed {
        logic        req;
        logic [31:0] cause;
        logic [31:0] offset;
    } trap_req_t;

    typedef struct packed {
        logic        req;
        dcsr_cause_e cause;
    } dbg_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } redirect_t;

endpackage

// File: hw/irq_arbiter.sv
/*
 * Interrupt and ecall arbiter.
 * Picks the highest priority enabled interrupt, lets a valid ecall override
 * it and presents the winner's cause and vector offset to the trap FSM.
 */
module irq_arbiter (
    input  trap_pkg::inst_info_t inst_i,
    input  trap_pkg::irq_lines_t irq_i,
    input  logic [31:0]          mie_i,
    input  logic [31:0]          mstatus_i,
    input  logic                 debug_mode_i,
    output trap_pkg::trap_req_t  trap_req_o
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic [3:0]  fast_id;
    logic        irq_hit;
    logic        irq_take;
    logic        ecall_take;
    logic [31:0] irq_cause;
    logic [31:0] irq_offset;

    // lowest set fast line wins
    always_comb begin
        fast_id = 4'd0;
        for (int i = 14; i >= 0; i--) begin
            if (irq_i.fast[i]) fast_id = 4'(i);
        end
    end

    always_comb begin
        irq_hit = 1'b1;
        if (|irq_i.fast) begin  // fast lines are always enabled
            irq_cause  = CAUSE_IRQ_FAST0 + {28'd0, fast_id};
            irq_offset = OFS_FAST + {26'd0, fast_id, 2'b00};
        end else if (irq_i.external && mie_i[MIE_MEIE_BIT]) begin
            irq_cause  = CAUSE_IRQ_EXTERNAL;
            irq_offset = OFS_EXTERNAL;
        end else if (irq_i.software && mie_i[MIE_MSIE_BIT]) begin
            irq_cause  = CAUSE_IRQ_SOFTWARE;
            irq_offset = OFS_SOFTWARE;
        end else if (irq_i.timer && mie_i[MIE_MTIE_BIT]) begin
            irq_cause  = CAUSE_IRQ_TIMER;
            irq_offset = OFS_TIMER;
        end else begin
            irq_hit    = 1'b0;
            irq_cause  = 32'h0;
            irq_offset = 32'h0;
        end
    end

    assign irq_take   = irq_hit && inst_i.valid && mstatus_i[MSTATUS_MIE_BIT] && !debug_mode_i;
    assign ecall_take = inst_i.valid && inst_i.ecall;

    assign trap_req_o.req    = irq_take || ecall_take;
    assign trap_req_o.cause  = ecall_take ? CAUSE_ECALL : irq_cause;
    assign trap_req_o.offset = ecall_take ? OFS_ECALL : irq_offset;

endmodule

// File: hw/debug_cause.sv
/*
 * Debug entry cause selection.
 * Ranks trigger, ebreak, reset halt, debugger request and single step, and
 * keeps a trigger disarmed for a few cycles after the debugger returns.
 */
module debug_cause (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::inst_info_t inst_i,
    input  logic                 debug_req_i,
    input  logic                 trigger_match_i,
    input  logic                 step_en_i,
    input  logic                 debug_mode_i,
    input  logic                 dret_taken_i,
    output trap_pkg::dbg_req_t   dbg_req_o
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic                    trig_armed_q;
    logic [TRIG_HOLDOFF-1:0] trig_dly_q;
    logic                    trig_hold;
    logic                    at_reset;
    dcsr_cause_e             cause;

    assign trig_hold = trig_dly_q[TRIG_HOLDOFF-1];  // delayed copy of the armed flag
    assign at_reset  = (inst_i.addr == CPU_RESET_ADDR);

    always_comb begin
        cause = NONE;
        if (inst_i.valid) begin
            if (trigger_match_i && !trig_hold) cause = TRIGGER;
            else if (inst_i.ebreak) cause = EBREAK;
            else if (debug_req_i && at_reset) cause = HALT;
            else if (debug_req_i && !debug_mode_i) cause = DBGREQ;
            else if (inst_i.executed && step_en_i && !debug_mode_i) cause = STEP;
        end
    end

    assign dbg_req_o.cause = cause;
    assign dbg_req_o.req   = inst_i.valid &&
                             ((trigger_match_i && !trig_hold) || inst_i.ebreak ||
                              (debug_req_i && (at_reset || !debug_mode_i)) ||
                              (inst_i.executed && step_en_i && !debug_mode_i));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_armed_q <= 1'b0;
            trig_dly_q   <= '0;
        end else begin
            if (dret_taken_i) trig_armed_q <= 1'b0;
            else if (cause == TRIGGER) trig_armed_q <= 1'b1;
            trig_dly_q <= {trig_dly_q[TRIG_HOLDOFF-2:0], trig_armed_q};  // holdoff chain
        end
    end

    a_cause_matches_req : assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_req_o.cause == NONE) == !dbg_req_o.req);

endmodule

// File: hw/trap_ctrl.sv
/*
 * Trap sequencing FSM.
 * Accepts an interrupt, ecall, debug entry, mret or dret from IDLE, writes the
 * affected CSRs one per cycle while stalling the pipeline, tracks debug mode
 * and pulses the redirect from the ASSERT state.
 */
module trap_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::inst_info_t inst_i,
    input  trap_pkg::trap_req_t  trap_req_i,
    input  trap_pkg::dbg_req_t   dbg_req_i,
    input  logic [31:0]          debug_halt_addr_i,
    input  logic [31:0]          mtvec_i,
    input  logic [31:0]          mepc_i,
    input  logic [31:0]          mstatus_i,
    input  logic [31:0]          dpc_i,
    input  logic [31:0]          dcsr_i,
    output csr_pkg::csr_wr_t     trap_csr_wr_o,
    output logic                 debug_mode_o,
    output logic                 dret_taken_o,
    output logic                 stall_o,
    output trap_pkg::redirect_t  redirect_o
);
    import csr_pkg::*;
    import trap_pkg::*;

    trap_state_e state_q, state_d;
    dcsr_cause_e cause_q, cause_d;
    logic        debug_mode_q, debug_mode_d;
    logic [31:0] assert_addr_q, assert_addr_d;  // redirect target
    logic [31:0] ret_addr_q, ret_addr_d;        // goes to mepc
    logic        trap_take;
    logic        mret_req;
    logic        dret_req;

    assign trap_take = trap_req_i.req && !debug_mode_q;
    assign mret_req  = inst_i.valid && inst_i.mret;
    assign dret_req  = inst_i.valid && inst_i.dret;

    always_comb begin
        state_d       = state_q;
        cause_d       = cause_q;
        debug_mode_d  = debug_mode_q;
        assert_addr_d = assert_addr_q;
        ret_addr_d    = ret_addr_q;
        trap_csr_wr_o = '0;
        dret_taken_o  = 1'b0;
        case (state_q)
            IDLE: begin
                if (trap_take) begin
                    trap_csr_wr_o.we   = 1'b1;
                    trap_csr_wr_o.addr = CSR_MCAUSE;
                    trap_csr_wr_o.data = trap_req_i.cause;
                    assert_addr_d      = mtvec_i + trap_req_i.offset;
                    ret_addr_d         = inst_i.addr;
                    state_d            = W_MSTATUS;
                end else if (dbg_req_i.req) begin
                    debug_mode_d  = 1'b1;
                    cause_d       = dbg_req_i.cause;
                    assert_addr_d = debug_halt_addr_i;
                    if (dbg_req_i.cause == EBREAK) begin  // dpc and dcsr left alone
                        state_d = ASSERT;
                    end else begin
                        trap_csr_wr_o.we   = 1'b1;
                        trap_csr_wr_o.addr = CSR_DPC;
                        trap_csr_wr_o.data = (dbg_req_i.cause == HALT) ? CPU_RESET_ADDR
                                                                       : inst_i.addr;
                        state_d            = W_DCSR;
                    end
                end else if (mret_req) begin
                    trap_csr_wr_o.we   = 1'b1;
                    trap_csr_wr_o.addr = CSR_MSTATUS;
                    trap_csr_wr_o.data = mstatus_i | (32'd1 << MSTATUS_MIE_BIT);
                    assert_addr_d      = mepc_i;
                    state_d            = ASSERT;
                end else if (dret_req) begin
                    debug_mode_d  = 1'b0;
                    dret_taken_o  = 1'b1;
                    assert_addr_d = dpc_i;
                    state_d       = ASSERT;
                end
            end
            W_MSTATUS: begin
                trap_csr_wr_o.we   = 1'b1;
                trap_csr_wr_o.addr = CSR_MSTATUS;
                trap_csr_wr_o.data = mstatus_i & ~(32'd1 << MSTATUS_MIE_BIT);  // mask irqs
                state_d            = W_MEPC;
            end
            W_MEPC: begin
                trap_csr_wr_o.we   = 1'b1;
                trap_csr_wr_o.addr = CSR_MEPC;
                trap_csr_wr_o.data = ret_addr_q;
                state_d            = ASSERT;
            end
            W_DCSR: begin
                trap_csr_wr_o.we   = 1'b1;
                trap_csr_wr_o.addr = CSR_DCSR;
                trap_csr_wr_o.data = (dcsr_i & ~(32'h7 << DCSR_CAUSE_LSB)) |
                                     ({29'd0, cause_q} << DCSR_CAUSE_LSB);
                state_d            = ASSERT;
            end
            ASSERT: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            cause_q      <= NONE;
            debug_mode_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            cause_q      <= cause_d;
            debug_mode_q <= debug_mode_d;
        end
    end

    always_ff @(posedge clk) begin
        assert_addr_q <= assert_addr_d;
        ret_addr_q    <= ret_addr_d;
    end

    assign debug_mode_o     = debug_mode_q;
    assign redirect_o.valid = (state_q == ASSERT);
    assign redirect_o.addr  = assert_addr_q;
    assign stall_o = (state_q inside {W_MSTATUS, W_MEPC, W_DCSR}) ||
                     ((state_q == IDLE) && (trap_take || dbg_req_i.req || mret_req || dret_req));

    a_state_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(state_q));
    a_redirect_after_stall : assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.valid |-> (state_q == ASSERT) && $past(stall_o));
    a_no_write_in_assert : assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == ASSERT) |-> !trap_csr_wr_o.we);

endmodule

// File: hw/trap_csr_file.sv
/*
 * Trap CSR file.
 * Holds mtvec, mepc, mcause, mstatus, mie, dpc and dcsr. A trap FSM write
 * wins over a core write in the same cycle; any address reads back
 * combinationally, unknown ones as zero.
 */
module trap_csr_file (
    input  logic             clk,
    input  logic             rst_n,
    input  csr_pkg::csr_wr_t trap_wr_i,
    input  csr_pkg::csr_wr_t core_wr_i,
    input  logic [11:0]      raddr_i,
    output logic [31:0]      rdata_o,
    output logic [31:0]      mtvec_o,
    output logic [31:0]      mepc_o,
    output logic [31:0]      mstatus_o,
    output logic [31:0]      mie_o,
    output logic [31:0]      dpc_o,
    output logic [31:0]      dcsr_o
);
    import csr_pkg::*;

    csr_wr_t     wr;
    logic [31:0] mtvec_q, mepc_q, mcause_q, mstatus_q, mie_q, dpc_q, dcsr_q;

    function automatic logic [31:0] csr_read(input logic [11:0] addr);
        case (addr)
            CSR_MTVEC:   return mtvec_q;
            CSR_MEPC:    return mepc_q;
            CSR_MCAUSE:  return mcause_q;
            CSR_MSTATUS: return mstatus_q;
            CSR_MIE:     return mie_q;
            CSR_DPC:     return dpc_q;
            CSR_DCSR:    return dcsr_q;
            default:     return 32'h0;
        endcase
    endfunction

    assign wr = trap_wr_i.we ? trap_wr_i : core_wr_i;  // trap side has priority

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q   <= MTVEC_RESET;
            mepc_q    <= 32'h0;
            mcause_q  <= 32'h0;
            mstatus_q <= 32'h0;
            mie_q     <= 32'h0;
            dpc_q     <= 32'h0;
            dcsr_q    <= 32'h0;
        end else if (wr.we) begin
            case (wr.addr)
                CSR_MTVEC:   mtvec_q   <= wr.data;
                CSR_MEPC:    mepc_q    <= wr.data;
                CSR_MCAUSE:  mcause_q  <= wr.data;
                CSR_MSTATUS: mstatus_q <= wr.data;
                CSR_MIE:     mie_q     <= wr.data;
                CSR_DPC:     dpc_q     <= wr.data;
                CSR_DCSR:    dcsr_q    <= wr.data;
                default: ;  // unmapped, dropped
            endcase
        end
    end

    always_comb rdata_o = csr_read(raddr_i);

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;
    assign mie_o     = mie_q;
    assign dpc_o     = dpc_q;
    assign dcsr_o    = dcsr_q;

    a_trap_write_lands : assert property (@(posedge clk) disable iff (!rst_n)
        trap_wr_i.we |=> csr_read($past(trap_wr_i.addr)) == $past(trap_wr_i.data));

endmodule

// File: hw/trap_unit.sv
/*
 * Trap and debug-entry unit top level.
 * Connects the interrupt arbiter, debug cause logic, trap FSM and CSR file.
 * The core holds inst_i while stall_o is high and follows redirect_o.
 */
module trap_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::inst_info_t inst_i,
    input  trap_pkg::irq_lines_t irq_i,
    input  logic                 debug_req_i,
    input  logic                 trigger_match_i,
    input  logic [31:0]          debug_halt_addr_i,
    input  csr_pkg::csr_wr_t     core_csr_i,
    input  logic [11:0]          csr_raddr_i,
    output logic                 stall_o,
    output trap_pkg::redirect_t  redirect_o,
    output logic [31:0]          csr_rdata_o
);
    import csr_pkg::*;
    import trap_pkg::*;

    trap_req_t   trap_req;
    dbg_req_t    dbg_req;
    csr_wr_t     trap_csr_wr;
    logic        debug_mode;
    logic        dret_taken;
    logic [31:0] mtvec, mepc, mstatus, mie, dpc, dcsr;  // csr view

    irq_arbiter u_irq_arbiter (
        .inst_i       (inst_i),
        .irq_i        (irq_i),
        .mie_i        (mie),
        .mstatus_i    (mstatus),
        .debug_mode_i (debug_mode),
        .trap_req_o   (trap_req)
    );

    debug_cause u_debug_cause (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_i          (inst_i),
        .debug_req_i     (debug_req_i),
        .trigger_match_i (trigger_match_i),
        .step_en_i       (dcsr[DCSR_STEP_BIT]),
        .debug_mode_i    (debug_mode),
        .dret_taken_i    (dret_taken),
        .dbg_req_o       (dbg_req)
    );

    trap_ctrl u_trap_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_i            (inst_i),
        .trap_req_i        (trap_req),
        .dbg_req_i         (dbg_req),
        .debug_halt_addr_i (debug_halt_addr_i),
        .mtvec_i           (mtvec),
        .mepc_i            (mepc),
        .mstatus_i         (mstatus),
        .dpc_i             (dpc),
        .dcsr_i            (dcsr),
        .trap_csr_wr_o     (trap_csr_wr),
        .debug_mode_o      (debug_mode),
        .dret_taken_o      (dret_taken),
        .stall_o           (stall_o),
        .redirect_o        (redirect_o)
    );

    trap_csr_file u_trap_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_wr_i (trap_csr_wr),
        .core_wr_i (core_csr_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mstatus_o (mstatus),
        .mie_o     (mie),
        .dpc_o     (dpc),
        .dcsr_o    (dcsr)
    );

endmodule

// File: verification/trap_unit_tb.sv
/*
 * Testbench for the trap unit.
 * Runs directed ecall, interrupt, mret and debug-entry sequences, keeps a
 * small reference model of the expected redirect and CSR read values and
 * checks the DUT against it with concurrent assertions. A watchdog bounds
 * the run.
 */
module trap_unit_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_SEQ    = 22;  // run_seq and idle_check calls
    localparam logic [31:0] MTVEC_VAL  = 32'h0000_0100;
    localparam logic [31:0] HALT_ADDR  = 32'h0000_0800;
    localparam logic [31:0] ALL_BITS   = 32'hffff_ffff;
    localparam logic [31:0] CAUSE_MASK = 32'h0000_01c0;  // dcsr cause field
    localparam logic [31:0] MIE_ON     = 32'd1 << MSTATUS_MIE_BIT;
    localparam logic [31:0] MIE_ALL    = (32'd1 << MIE_MEIE_BIT) | (32'd1 << MIE_MSIE_BIT) |
                                         (32'd1 << MIE_MTIE_BIT);

    // instruction kinds as {valid, executed, ecall, ebreak, mret, dret}
    localparam logic [5:0] K_PLAIN  = 6'b100000;
    localparam logic [5:0] K_EXEC   = 6'b110000;
    localparam logic [5:0] K_ECALL  = 6'b101000;
    localparam logic [5:0] K_EBREAK = 6'b100100;
    localparam logic [5:0] K_MRET   = 6'b100010;
    localparam logic [5:0] K_DRET   = 6'b100001;

    logic        clk = 1'b0;
    logic        rst_n;
    inst_info_t  inst_i;
    irq_lines_t  irq_i;
    logic        debug_req_i;
    logic        trigger_match_i;
    logic [31:0] debug_halt_addr_i;
    csr_wr_t     core_csr_i;
    logic [11:0] csr_raddr_i;
    logic        stall_o;
    redirect_t   redirect_o;
    logic [31:0] csr_rdata_o;

    int          exp_cnt;    // cycles until the expected redirect, 1 means this cycle
    logic [31:0] exp_addr;
    logic        chk_en;
    logic [31:0] chk_mask;
    logic [31:0] exp_rdata;
    logic        quiet;      // neither stall nor redirect expected
    logic [31:0] epc_model;
    integer      seed;
    integer      rnd;
    logic [14:0] pattern;
    int          idx;

    trap_unit UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_i            (inst_i),
        .irq_i             (irq_i),
        .debug_req_i       (debug_req_i),
        .trigger_match_i   (trigger_match_i),
        .debug_halt_addr_i (debug_halt_addr_i),
        .core_csr_i        (core_csr_i),
        .csr_raddr_i       (csr_raddr_i),
        .stall_o           (stall_o),
        .redirect_o        (redirect_o),
        .csr_rdata_o       (csr_rdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_fail(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
        stop_fail();
    endtask

    function automatic inst_info_t instr(input logic [5:0] kind, input logic [31:0] addr);
        return {kind, addr};
    endfunction

    function automatic int lowest_set(input logic [14:0] v);
        int n;
        n = 0;
        while (n < 14 && !v[n]) n++;
        return n;
    endfunction

    function automatic logic [31:0] dcsr_field(input logic [2:0] cause);
        return {29'd0, cause} << DCSR_CAUSE_LSB;
    endfunction

    task automatic tick();
        @(posedge clk);
        if (exp_cnt != 0) exp_cnt <= exp_cnt - 1;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        core_csr_i <= {1'b1, addr, data};
        tick();
        core_csr_i <= '0;
    endtask

    task automatic check_csr(input logic [11:0] addr, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_raddr_i <= addr;
        chk_mask    <= mask;
        exp_rdata   <= value;
        chk_en      <= 1'b1;
        tick();
        chk_en <= 1'b0;
    endtask

    // apply a request and hold it until the DUT redirects
    task automatic run_seq(input inst_info_t inst, input irq_lines_t irq, input logic [1:0] dbg,
                           input int latency, input logic [31:0] target);
        inst_i                           <= inst;
        irq_i                            <= irq;
        {debug_req_i, trigger_match_i}   <= dbg;
        exp_cnt                          <= latency;
        exp_addr                         <= target;
        tick();
        while (!redirect_o.valid) tick();
        inst_i                         <= '0;
        irq_i                          <= '0;
        {debug_req_i, trigger_match_i} <= 2'b00;
    endtask

    // apply a request that must be ignored
    task automatic idle_check(input inst_info_t inst, input irq_lines_t irq,
                              input logic [1:0] dbg, input int cycles);
        inst_i                         <= inst;
        irq_i                          <= irq;
        {debug_req_i, trigger_match_i} <= dbg;
        quiet                          <= 1'b1;
        repeat (cycles) tick();
        inst_i                         <= '0;
        irq_i                          <= '0;
        {debug_req_i, trigger_match_i} <= 2'b00;
        quiet                          <= 1'b0;
    endtask

    a_redirect_valid : assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.valid == (exp_cnt == 1))
        else value_fail("redirect_o.valid", 32'($sampled(redirect_o.valid)),
                        32'($sampled(exp_cnt == 1)));
    a_redirect_addr : assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.valid |-> (redirect_o.addr == exp_addr))
        else value_fail("redirect_o.addr", $sampled(redirect_o.addr), $sampled(exp_addr));
    a_csr_read : assert property (@(posedge clk) disable iff (!rst_n)
        chk_en |-> ((csr_rdata_o & chk_mask) == exp_rdata))
        else value_fail("csr_rdata_o", $sampled(csr_rdata_o) & $sampled(chk_mask),
                        $sampled(exp_rdata));
    a_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> !stall_o)
        else value_fail("stall_o", 32'($sampled(stall_o)), 32'h0);

    initial begin
        #(NUM_SEQ * 40 * CLK_PERIOD);
        $display("Timeout: the test sequences did not finish in time");
        stop_fail();
    end

    initial begin
        seed = 4258;
        rst_n             <= 1'b0;
        inst_i            <= '0;
        irq_i             <= '0;
        debug_req_i       <= 1'b0;
        trigger_match_i   <= 1'b0;
        debug_halt_addr_i <= HALT_ADDR;
        core_csr_i        <= '0;
        csr_raddr_i       <= '0;
        exp_cnt           <= 0;
        exp_addr          <= '0;
        chk_en            <= 1'b0;
        chk_mask          <= '0;
        exp_rdata         <= '0;
        quiet             <= 1'b0;
        tick();
        tick();
        rst_n <= 1'b1;

        write_csr(CSR_MSTATUS, MIE_ON);  // ecall must clear MIE
        epc_model = 32'h0000_1234;
        run_seq(instr(K_ECALL, epc_model), '0, 2'b00, 4, MTVEC_VAL + 32'd8);
        check_csr(CSR_MCAUSE, ALL_BITS, 32'h0000_000b);
        check_csr(CSR_MEPC, ALL_BITS, epc_model);
        check_csr(CSR_MSTATUS, MIE_ON, 32'h0);

        write_csr(CSR_MIE, MIE_ALL);
        epc_model = 32'h0000_1400;
        for (int k = 0; k < 3; k++) begin
            rnd     = $random(seed);
            pattern = (rnd[14:0] == 15'h0) ? 15'h0001 : rnd[14:0];
            idx     = lowest_set(pattern);
            write_csr(CSR_MSTATUS, MIE_ON);
            run_seq(instr(K_PLAIN, epc_model), {3'b000, pattern}, 2'b00, 4,
                    MTVEC_VAL + 32'd44 + 32'(4 * idx));
            check_csr(CSR_MCAUSE, ALL_BITS, 32'h8000_0010 + 32'(idx));
        end

        // external over software over timer
        write_csr(CSR_MSTATUS, MIE_ON);
        run_seq(instr(K_PLAIN, epc_model), {3'b111, 15'h0}, 2'b00, 4, MTVEC_VAL + 32'd32);
        check_csr(CSR_MCAUSE, ALL_BITS, 32'h8000_000b);
        write_csr(CSR_MSTATUS, MIE_ON);
        run_seq(instr(K_PLAIN, epc_model), {3'b110, 15'h0}, 2'b00, 4, MTVEC_VAL + 32'd36);
        check_csr(CSR_MCAUSE, ALL_BITS, 32'h8000_0003);
        write_csr(CSR_MSTATUS, MIE_ON);
        run_seq(instr(K_PLAIN, epc_model), {3'b010, 15'h0}, 2'b00, 4, MTVEC_VAL + 32'd40);
        check_csr(CSR_MCAUSE, ALL_BITS, 32'h8000_0007);

        write_csr(CSR_MIE, 32'h0);  // masked by mie
        write_csr(CSR_MSTATUS, MIE_ON);
        idle_check(instr(K_PLAIN, 32'h0000_1480), {3'b111, 15'h0}, 2'b00, 4);
        write_csr(CSR_MIE, MIE_ALL);  // masked by global MIE
        write_csr(CSR_MSTATUS, 32'h0);
        idle_check(instr(K_PLAIN, 32'h0000_1484), {3'b111, 15'h0001}, 2'b00, 4);

        run_seq(instr(K_MRET, 32'h0000_1500), '0, 2'b00, 2, epc_model);
        check_csr(CSR_MSTATUS, MIE_ON, MIE_ON);

        run_seq(instr(K_PLAIN, 32'h0000_2000), '0, 2'b10, 3, HALT_ADDR);
        check_csr(CSR_DPC, ALL_BITS, 32'h0000_2000);
        check_csr(CSR_DCSR, CAUSE_MASK, dcsr_field(DBGREQ));
        idle_check(instr(K_PLAIN, 32'h0000_2004), {3'b001, 15'h0}, 2'b00, 4);
        run_seq(instr(K_DRET, 32'h0000_2008), '0, 2'b00, 2, 32'h0000_2000);

        run_seq(instr(K_EBREAK, 32'h0000_3000), '0, 2'b00, 2, HALT_ADDR);
        check_csr(CSR_DPC, ALL_BITS, 32'h0000_2000);
        check_csr(CSR_DCSR, ALL_BITS, dcsr_field(DBGREQ));
        run_seq(instr(K_DRET, 32'h0000_3004), '0, 2'b00, 2, 32'h0000_2000);

        run_seq(instr(K_PLAIN, 32'h0000_4000), '0, 2'b01, 3, HALT_ADDR);
        check_csr(CSR_DPC, ALL_BITS, 32'h0000_4000);
        check_csr(CSR_DCSR, CAUSE_MASK, dcsr_field(TRIGGER));
        repeat (3) tick();  // holdoff chain fills while in debug mode
        run_seq(instr(K_DRET, 32'h0000_4004), '0, 2'b00, 2, 32'h0000_4000);
        idle_check(instr(K_PLAIN, 32'h0000_4008), '0, 2'b01, TRIG_HOLDOFF - 2);

        write_csr(CSR_DCSR, 32'd1 << DCSR_STEP_BIT);
        run_seq(instr(K_EXEC, 32'h0000_5000), '0, 2'b00, 3, HALT_ADDR);
        check_csr(CSR_DPC, ALL_BITS, 32'h0000_5000);
        check_csr(CSR_DCSR, CAUSE_MASK, dcsr_field(STEP));
        run_seq(instr(K_DRET, 32'h0000_5004), '0, 2'b00, 2, 32'h0000_5000);
        write_csr(CSR_DCSR, 32'h0);

        run_seq(instr(K_PLAIN, CPU_RESET_ADDR), '0, 2'b10, 3, HALT_ADDR);  // halt on reset
        check_csr(CSR_DPC, ALL_BITS, CPU_RESET_ADDR);
        check_csr(CSR_DCSR, CAUSE_MASK, dcsr_field(HALT));
        run_seq(instr(K_DRET, 32'h0000_6000), '0, 2'b00, 2, CPU_RESET_ADDR);

        tick();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: sources.f
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/irq_arbiter.sv
hw/debug_cause.sv
hw/trap_ctrl.sv
hw/trap_csr_file.sv
hw/trap_unit.sv
verification/trap_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trap_unit_tb \
    -f sources.f -o trap_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/trap_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
